// File: source/dbg_boot_consts.svh
/*
 * Debug and boot corner constants
 * RAM geometry, software status and log addresses, SPI boot frame length
 */

`ifndef DBG_BOOT_CONSTS_SVH
`define DBG_BOOT_CONSTS_SVH

// Main RAM geometry
`define RAM_WORDS 256
`define RAM_AW 8

// Byte addresses that software writes to report progress
// Both lie inside the RAM so the writes also land in memory
`define STATUS_ADDR 16'h03f8
`define LOG_ADDR 16'h03fc

// One boot frame, 16-bit byte address then 32-bit data, MSB first
`define SPI_FRAME_BITS 48

`endif

// File: source/dbg_boot_pkg.sv
/*
 * Debug and boot package
 * Shared data, address and debug-port mode types
 */

`default_nettype none

package dbg_boot_pkg;

  // One RAM data word
  typedef logic [31:0] word_t;

  // Byte address, bits 9 to 2 select the RAM word
  typedef logic [15:0] baddr_t;

  // Debug port mode, taken from the jtag_spi_n strap
  typedef enum logic {
    DPS_SPI  = 1'b0,
    DPS_JTAG = 1'b1
  } dps_mode_e;

endpackage

`default_nettype wire

// File: source/ram_bus_if.sv
/*
 * Single-cycle RAM request bus
 * One access per cycle with req high, read data one cycle later
 */

`timescale 1ns/1ps
`default_nettype none

interface ram_bus_if;

  logic                   req;
  logic                   we;
  dbg_boot_pkg::baddr_t   addr;
  dbg_boot_pkg::word_t    wdata;
  dbg_boot_pkg::word_t    rdata;

  // Requester side
  modport master (
    output req, we, addr, wdata,
    input  rdata
  );

  // Responder side
  modport slave (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: source/dps_pad_mux.sv
/*
 * Debug port pad mux
 * Latches the straps, routes the shared pins to SPI or JTAG,
 * and holds the JTAG bypass register
 */

`timescale 1ns/1ps
`default_nettype none

module dps_pad_mux (
  input  wire logic                    clk_i,
  input  wire logic                    arst_n_i,
  input  wire logic                    sck_tck_i,
  input  wire logic                    mosi_tdi_i,
  input  wire logic                    csb_tms_i,
  input  wire logic                    trst_n_i,
  input  wire logic                    jtag_spi_n_i,
  input  wire logic                    bootstrap_i,
  input  wire logic                    spi_miso_i,
  output logic                         miso_tdo_o,
  output logic                         spi_sck_o,
  output logic                         spi_mosi_o,
  output logic                         spi_csb_o,
  output logic                         boot_mode_o,
  output dbg_boot_pkg::dps_mode_e      mode_o
);

  // Pin order {trst_n, csb_tms, mosi_tdi, sck_tck}
  logic [3:0] sync1_q;
  logic [3:0] sync2_q;

  logic                    strap_done_q;
  logic                    boot_q;
  dbg_boot_pkg::dps_mode_e mode_q;

  logic tck_q;
  logic bypass_q;
  logic in_jtag;
  logic tck_rise;

  // Two-flop synchronizers, csb idles high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync1_q <= 4'b0100;
      sync2_q <= 4'b0100;
    end else begin
      sync1_q <= {trst_n_i, csb_tms_i, mosi_tdi_i, sck_tck_i};
      sync2_q <= sync1_q;
    end
  end

  // Straps are sampled once, on the first edge out of reset
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      strap_done_q <= 1'b0;
      boot_q       <= 1'b0;
      mode_q       <= dbg_boot_pkg::DPS_SPI;
    end else if (!strap_done_q) begin
      strap_done_q <= 1'b1;
      boot_q       <= bootstrap_i;
      mode_q       <= jtag_spi_n_i ? dbg_boot_pkg::DPS_JTAG : dbg_boot_pkg::DPS_SPI;
    end
  end

  assign in_jtag  = (mode_q == dbg_boot_pkg::DPS_JTAG);
  assign tck_rise = in_jtag & sync2_q[0] & ~tck_q;

  // Bypass register, TDI shows on TDO one TCK later
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tck_q    <= 1'b0;
      bypass_q <= 1'b0;
    end else begin
      tck_q <= sync2_q[0];
      if (!sync2_q[3]) begin
        bypass_q <= 1'b0;
      end else if (tck_rise) begin
        bypass_q <= sync2_q[1];
      end
    end
  end

  // SPI side sees an idle bus while JTAG owns the pins
  assign spi_sck_o  = ~in_jtag & sync2_q[0];
  assign spi_mosi_o = sync2_q[1];
  assign spi_csb_o  = in_jtag | sync2_q[2];

  assign miso_tdo_o  = in_jtag ? bypass_q : spi_miso_i;
  assign boot_mode_o = boot_q;
  assign mode_o      = mode_q;

endmodule

`default_nettype wire

// File: source/spi_boot_loader.sv
/*
 * SPI boot loader
 * Collects 48-bit frames and turns each complete one into a RAM write
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_boot_consts.svh"

module spi_boot_loader (
  input  wire logic  clk_i,
  input  wire logic  arst_n_i,
  input  wire logic  sck_i,
  input  wire logic  mosi_i,
  input  wire logic  csb_i,
  output logic       miso_o,
  ram_bus_if.master  boot
);

  // Edge detection against the previous clock
  logic sck_q;
  logic csb_q;
  logic sck_rise;
  logic csb_rise;
  logic frame_ok;

  // Saturating bit count, one bit wider than needed for a full frame
  logic [$clog2(`SPI_FRAME_BITS):0] cnt_q;

  logic [`SPI_FRAME_BITS-1:0] shift_q;
  logic [`SPI_FRAME_BITS-1:0] frame_q;

  logic miso_q;
  logic pend_q;
  logic req_q;

  assign sck_rise = sck_i & ~sck_q & ~csb_i;
  assign csb_rise = csb_i & ~csb_q;
  assign frame_ok = csb_rise && (cnt_q == `SPI_FRAME_BITS);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_q  <= 1'b0;
      csb_q  <= 1'b1;
      cnt_q  <= '0;
      miso_q <= 1'b0;
      pend_q <= 1'b0;
      req_q  <= 1'b0;
    end else begin
      sck_q  <= sck_i;
      csb_q  <= csb_i;
      // Frame captured this cycle, write goes out on the next
      pend_q <= frame_ok;
      req_q  <= pend_q;
      if (csb_i) begin
        cnt_q <= '0;
      end else if (sck_rise && (cnt_q != '1)) begin
        cnt_q <= cnt_q + 1'b1;
      end
      // Echo of the last received bit for link checks
      if (sck_rise) begin
        miso_q <= mosi_i;
      end
    end
  end

  // Frame data path
  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      shift_q <= {shift_q[`SPI_FRAME_BITS-2:0], mosi_i};
    end
    if (frame_ok) begin
      frame_q <= shift_q;
    end
  end

  assign miso_o = miso_q;

  // Address in the upper bits, data word below
  assign boot.req   = req_q;
  assign boot.we    = req_q;
  assign boot.addr  = frame_q[`SPI_FRAME_BITS-1 -: 16];
  assign boot.wdata = frame_q[31:0];

endmodule

`default_nettype wire

// File: source/ram_main.sv
/*
 * Main RAM
 * CPU and boot write ports, owner chosen by the boot strap
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_boot_consts.svh"

module ram_main (
  input  wire logic  clk_i,
  input  wire logic  arst_n_i,
  input  wire logic  boot_mode_i,
  ram_bus_if.slave   cpu,
  ram_bus_if.slave   boot,
  ram_bus_if.master  mem
);

  dbg_boot_pkg::word_t  mem_q [`RAM_WORDS];
  dbg_boot_pkg::word_t  rdata_q;

  logic                 wr_en;
  dbg_boot_pkg::baddr_t wr_addr;
  dbg_boot_pkg::word_t  wr_data;

  // Only the owning port may write
  always_comb begin
    if (boot_mode_i) begin
      wr_en   = boot.req & boot.we;
      wr_addr = boot.addr;
      wr_data = boot.wdata;
    end else begin
      wr_en   = cpu.req & cpu.we;
      wr_addr = cpu.addr;
      wr_data = cpu.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_addr[`RAM_AW+1:2]] <= wr_data;
    end
  end

  // CPU reads in either mode
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rdata_q <= '0;
    end else if (cpu.req && !cpu.we) begin
      rdata_q <= mem_q[cpu.addr[`RAM_AW+1:2]];
    end
  end

  assign cpu.rdata  = rdata_q;
  // Boot port is write-only
  assign boot.rdata = '0;

  // Copy of the write that reached the array
  assign mem.req   = wr_en;
  assign mem.we    = wr_en;
  assign mem.addr  = wr_addr;
  assign mem.wdata = wr_data;

endmodule

`default_nettype wire

// File: source/sw_status_snoop.sv
/*
 * Software status snooper
 * Picks test-status and log words out of RAM write traffic
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_boot_consts.svh"

module sw_status_snoop (
  input  wire logic            clk_i,
  input  wire logic            arst_n_i,
  ram_bus_if.slave             mem,
  output logic                 status_valid_o,
  output logic                 log_valid_o,
  output dbg_boot_pkg::word_t  status_code_o,
  output dbg_boot_pkg::word_t  log_data_o
);

  logic status_hit;
  logic log_hit;
  logic status_valid_q;
  logic log_valid_q;
  dbg_boot_pkg::word_t status_code_q;
  dbg_boot_pkg::word_t log_data_q;

  // Full byte address match, not just the word index
  assign status_hit = mem.req & mem.we & (mem.addr == `STATUS_ADDR);
  assign log_hit    = mem.req & mem.we & (mem.addr == `LOG_ADDR);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      status_valid_q <= 1'b0;
      log_valid_q    <= 1'b0;
    end else begin
      status_valid_q <= status_hit;
      log_valid_q    <= log_hit;
    end
  end

  always_ff @(posedge clk_i) begin
    if (status_hit) status_code_q <= mem.wdata;
    if (log_hit) log_data_q <= mem.wdata;
  end

  // Nothing to return to the monitor bus
  assign mem.rdata = '0;

  assign status_valid_o = status_valid_q;
  assign log_valid_o    = log_valid_q;
  assign status_code_o  = status_code_q;
  assign log_data_o     = log_data_q;

endmodule

`default_nettype wire

// File: source/dbg_boot_top.sv
/*
 * Debug and boot top level
 * Pad mux, SPI boot loader, main RAM and status snooper
 */

`timescale 1ns/1ps
`default_nettype none

module dbg_boot_top (
  input  wire logic                  clk_i,
  input  wire logic                  arst_n_i,
  // Shared debug port pins and straps
  input  wire logic                  sck_tck_i,
  input  wire logic                  mosi_tdi_i,
  input  wire logic                  csb_tms_i,
  input  wire logic                  trst_n_i,
  input  wire logic                  jtag_spi_n_i,
  input  wire logic                  bootstrap_i,
  output logic                       miso_tdo_o,
  // Processor stand-in
  input  wire logic                  cpu_req_i,
  input  wire logic                  cpu_we_i,
  input  dbg_boot_pkg::baddr_t       cpu_addr_i,
  input  dbg_boot_pkg::word_t        cpu_wdata_i,
  output dbg_boot_pkg::word_t        cpu_rdata_o,
  // Software reports
  output logic                       status_valid_o,
  output dbg_boot_pkg::word_t        status_code_o,
  output logic                       log_valid_o,
  output dbg_boot_pkg::word_t        log_data_o
);

  logic                    spi_sck;
  logic                    spi_mosi;
  logic                    spi_csb;
  logic                    spi_miso;
  logic                    boot_mode;
  dbg_boot_pkg::dps_mode_e dps_mode;

  ram_bus_if cpu_bus ();
  ram_bus_if boot_bus ();
  ram_bus_if mem_bus ();

  assign cpu_bus.req   = cpu_req_i;
  assign cpu_bus.we    = cpu_we_i;
  assign cpu_bus.addr  = cpu_addr_i;
  assign cpu_bus.wdata = cpu_wdata_i;
  assign cpu_rdata_o   = cpu_bus.rdata;

  dps_pad_mux u_pad_mux (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .sck_tck_i    (sck_tck_i),
    .mosi_tdi_i   (mosi_tdi_i),
    .csb_tms_i    (csb_tms_i),
    .trst_n_i     (trst_n_i),
    .jtag_spi_n_i (jtag_spi_n_i),
    .bootstrap_i  (bootstrap_i),
    .spi_miso_i   (spi_miso),
    .miso_tdo_o   (miso_tdo_o),
    .spi_sck_o    (spi_sck),
    .spi_mosi_o   (spi_mosi),
    .spi_csb_o    (spi_csb),
    .boot_mode_o  (boot_mode),
    .mode_o       (dps_mode)
  );

  spi_boot_loader u_boot_loader (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .sck_i    (spi_sck),
    .mosi_i   (spi_mosi),
    .csb_i    (spi_csb),
    .miso_o   (spi_miso),
    .boot     (boot_bus.master)
  );

  ram_main u_ram_main (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .boot_mode_i (boot_mode),
    .cpu         (cpu_bus.slave),
    .boot        (boot_bus.slave),
    .mem         (mem_bus.master)
  );

  sw_status_snoop u_status_snoop (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .mem            (mem_bus.slave),
    .status_valid_o (status_valid_o),
    .log_valid_o    (log_valid_o),
    .status_code_o  (status_code_o),
    .log_data_o     (log_data_o)
  );

endmodule

`default_nettype wire

// File: bench/dbg_boot_chk.sv
/*
 * Debug and boot checker
 * Concurrent assertions on the report outputs and the pad mux
 */

`timescale 1ns/1ps
`default_nettype none

module dbg_boot_chk (
  input  wire logic              clk_i,
  input  wire logic              arst_n_i,
  input  wire logic              status_valid_i,
  input  wire logic              log_valid_i,
  input  wire logic              spi_csb_i,
  input  dbg_boot_pkg::dps_mode_e mode_i
);

  int unsigned fail_cnt = 0;

  // Reports stay quiet while reset is held
  valid_low_in_reset: assert property (
    @(posedge clk_i) !arst_n_i |-> (!status_valid_i && !log_valid_i)
  ) else begin
    $error("report valid high during reset");
    fail_cnt++;
  end

  // One address per write, so at most one report
  one_report_at_a_time: assert property (
    @(posedge clk_i) disable iff (!arst_n_i) !(status_valid_i && log_valid_i)
  ) else begin
    $error("status and log valid high together");
    fail_cnt++;
  end

  // Loader sees an idle bus while JTAG owns the pins
  csb_idle_in_jtag: assert property (
    @(posedge clk_i) disable iff (!arst_n_i)
      (mode_i == dbg_boot_pkg::DPS_JTAG) |-> spi_csb_i
  ) else begin
    $error("internal SPI csb low in JTAG mode");
    fail_cnt++;
  end

endmodule

bind dbg_boot_top dbg_boot_chk u_chk (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .status_valid_i (status_valid_o),
  .log_valid_i    (log_valid_o),
  .spi_csb_i      (spi_csb),
  .mode_i         (dps_mode)
);

`default_nettype wire

// File: bench/tb_dbg_boot.sv
/*
 * Testbench for the debug and boot top level
 * Boot loading, bad frames, RAM ownership, status snooping, JTAG bypass
 */

`timescale 1ns/1ps
`default_nettype none

`include "dbg_boot_consts.svh"

module tb_dbg_boot;

  localparam int MAX_CYCLES = 20000;

  logic clk;
  logic arst_n;
  logic sck_tck;
  logic mosi_tdi;
  logic csb_tms;
  logic trst_n;
  logic jtag_spi_n;
  logic bootstrap;
  logic miso_tdo;
  logic cpu_req;
  logic cpu_we;
  dbg_boot_pkg::baddr_t cpu_addr;
  dbg_boot_pkg::word_t  cpu_wdata;
  dbg_boot_pkg::word_t  cpu_rdata;
  logic status_valid;
  logic log_valid;
  dbg_boot_pkg::word_t  status_code;
  dbg_boot_pkg::word_t  log_data;

  logic [31:0] lfsr_state;
  string       cur_test;
  int          err_cnt;
  int          test_err_start;
  int          tests_run;
  int          tests_failed;
  int          status_pulses;
  int          log_pulses;
  int          cycle_cnt;

  dbg_boot_pkg::baddr_t load_addr [6];
  dbg_boot_pkg::word_t  load_data [6];

  dbg_boot_top DUT (
    .clk_i          (clk),
    .arst_n_i       (arst_n),
    .sck_tck_i      (sck_tck),
    .mosi_tdi_i     (mosi_tdi),
    .csb_tms_i      (csb_tms),
    .trst_n_i       (trst_n),
    .jtag_spi_n_i   (jtag_spi_n),
    .bootstrap_i    (bootstrap),
    .miso_tdo_o     (miso_tdo),
    .cpu_req_i      (cpu_req),
    .cpu_we_i       (cpu_we),
    .cpu_addr_i     (cpu_addr),
    .cpu_wdata_i    (cpu_wdata),
    .cpu_rdata_o    (cpu_rdata),
    .status_valid_o (status_valid),
    .status_code_o  (status_code),
    .log_valid_o    (log_valid),
    .log_data_o     (log_data)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk);
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s %s: expected %h, actual %h", cur_test, what, exp, act);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = err_cnt;
  endtask

  task automatic end_test();
    int n;
    n = err_cnt - test_err_start;
    tests_run++;
    if (n != 0) begin
      tests_failed++;
    end
    $display("Test %s done, %0d errors", cur_test, n);
  endtask

  task automatic reset_with_straps(input logic jtag, input logic boot);
    arst_n     = 1'b0;
    jtag_spi_n = jtag;
    bootstrap  = boot;
    sck_tck    = 1'b0;
    csb_tms    = 1'b1;
    trst_n     = 1'b1;
    wait_clks(4);
    arst_n = 1'b1;
    // Straps latch on the next rising edge, then the synchronizers settle
    wait_clks(4);
  endtask

  // Sends bits[nbits-1:0] MSB first, edges 4 clocks apart
  task automatic spi_frame(input logic [63:0] bits, input int nbits, input bit echo_chk);
    logic b;
    csb_tms = 1'b0;
    wait_clks(4);
    for (int i = nbits - 1; i >= 0; i--) begin
      b        = bits[i];
      mosi_tdi = b;
      wait_clks(4);
      // MISO still shows the bit taken at the previous sck edge
      if (echo_chk && i < nbits - 1) begin
        check_value("miso echo", {31'd0, bits[i+1]}, {31'd0, miso_tdo});
      end
      sck_tck = 1'b1;
      wait_clks(4);
      sck_tck = 1'b0;
    end
    wait_clks(4);
    if (echo_chk) begin
      check_value("miso echo", {31'd0, bits[0]}, {31'd0, miso_tdo});
    end
    csb_tms = 1'b1;
    // Write lands 5 clocks after csb at the pin
    wait_clks(8);
  endtask

  task automatic jtag_bit(input logic tdi, output logic tdo);
    mosi_tdi = tdi;
    wait_clks(4);
    tdo     = miso_tdo;
    sck_tck = 1'b1;
    wait_clks(4);
    sck_tck = 1'b0;
  endtask

  task automatic cpu_write(input dbg_boot_pkg::baddr_t addr, input dbg_boot_pkg::word_t data);
    cpu_req   = 1'b1;
    cpu_we    = 1'b1;
    cpu_addr  = addr;
    cpu_wdata = data;
    wait_clks(1);
    cpu_req = 1'b0;
    cpu_we  = 1'b0;
  endtask

  task automatic cpu_read(input dbg_boot_pkg::baddr_t addr, output dbg_boot_pkg::word_t data);
    cpu_req  = 1'b1;
    cpu_we   = 1'b0;
    cpu_addr = addr;
    wait_clks(1);
    cpu_req = 1'b0;
    data    = cpu_rdata;
  endtask

  // Report pulses, counted where the outputs are stable
  always @(negedge clk) begin
    if (status_valid) status_pulses++;
    if (log_valid) log_pulses++;
  end

  initial begin
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, the tests did not finish", MAX_CYCLES);
    $display("Testbench failed");
    $finish;
  end

  initial begin
    dbg_boot_pkg::word_t  w;
    dbg_boot_pkg::word_t  v;
    dbg_boot_pkg::word_t  rd;
    dbg_boot_pkg::baddr_t a;
    logic b;
    logic tdo;
    logic prev;
    arst_n = 1'b0;
    sck_tck = 1'b0;
    mosi_tdi = 1'b0;
    csb_tms = 1'b1;
    trst_n = 1'b1;
    jtag_spi_n = 1'b0;
    bootstrap = 1'b0;
    cpu_req = 1'b0;
    cpu_we = 1'b0;
    cpu_addr = '0;
    cpu_wdata = '0;
    lfsr_state = 32'ha1f;
    err_cnt = 0;
    tests_run = 0;
    tests_failed = 0;
    status_pulses = 0;
    log_pulses = 0;
    cycle_cnt = 0;
    @(negedge clk);

    start_test("bootstrap_load");
    reset_with_straps(1'b0, 1'b1);
    for (int i = 0; i < 6; i++) begin
      load_addr[i] = {6'd0, 8'(i * 37 + 5), 2'b00};
      load_data[i] = rand_word(32);
      spi_frame({load_addr[i], load_data[i]}, `SPI_FRAME_BITS, 1'b0);
    end
    for (int i = 0; i < 6; i++) begin
      cpu_read(load_addr[i], rd);
      check_value("readback", load_data[i], rd);
    end
    end_test();

    start_test("bad_frames");
    reset_with_straps(1'b0, 1'b1);
    a = 16'h0200;
    // Word low byte equals the upper address byte
    // A short frame that slipped through would then hit the same word
    w = rand_word(24);
    w = {w[23:0], a[15:8]};
    spi_frame({a, w}, `SPI_FRAME_BITS, 1'b1);
    cpu_read(a, rd);
    check_value("good frame", w, rd);
    v = rand_word(32);
    spi_frame({a[7:0], v}, 40, 1'b1);
    cpu_read(a, rd);
    check_value("after 40-bit frame", w, rd);
    // Last 48 bits of this frame address the same word
    spi_frame({8'h3c, a, v}, 56, 1'b1);
    cpu_read(a, rd);
    check_value("after 56-bit frame", w, rd);
    end_test();

    start_test("ownership");
    reset_with_straps(1'b0, 1'b1);
    a = 16'h0120;
    w = rand_word(32);
    spi_frame({a, w}, `SPI_FRAME_BITS, 1'b0);
    cpu_write(a, ~w);
    cpu_read(a, rd);
    check_value("cpu write in boot mode", w, rd);
    // Straps move after reset, latched values must hold
    bootstrap  = 1'b0;
    jtag_spi_n = 1'b1;
    cpu_write(a, w ^ 32'h5555_aaaa);
    cpu_read(a, rd);
    check_value("cpu write after strap change", w, rd);
    w = rand_word(32);
    spi_frame({a, w}, `SPI_FRAME_BITS, 1'b0);
    cpu_read(a, rd);
    check_value("boot frame after strap change", w, rd);
    reset_with_straps(1'b0, 1'b0);
    v = rand_word(32);
    spi_frame({a, v}, `SPI_FRAME_BITS, 1'b0);
    cpu_read(a, rd);
    check_value("spi frame in cpu mode", w, rd);
    cpu_write(a, v);
    cpu_read(a, rd);
    check_value("cpu write in cpu mode", v, rd);
    bootstrap  = 1'b1;
    jtag_spi_n = 1'b1;
    w = rand_word(32);
    spi_frame({a, w}, `SPI_FRAME_BITS, 1'b0);
    cpu_read(a, rd);
    check_value("spi frame after strap change", v, rd);
    cpu_write(a, w);
    cpu_read(a, rd);
    check_value("cpu write after strap change", w, rd);
    end_test();

    start_test("status_log_snoop");
    reset_with_straps(1'b0, 1'b0);
    w = rand_word(32);
    status_pulses = 0;
    log_pulses = 0;
    cpu_write(`STATUS_ADDR, w);
    wait_clks(4);
    check_value("status pulses", 1, status_pulses);
    check_value("log pulses", 0, log_pulses);
    check_value("status code", w, status_code);
    v = rand_word(32);
    status_pulses = 0;
    cpu_write(`LOG_ADDR, v);
    wait_clks(4);
    check_value("status pulses", 0, status_pulses);
    check_value("log pulses", 1, log_pulses);
    check_value("log data", v, log_data);
    log_pulses = 0;
    // Same word index as the status address, different byte address
    cpu_write(16'h13f8, rand_word(32));
    cpu_write(16'h0100, rand_word(32));
    wait_clks(4);
    check_value("status pulses, other address", 0, status_pulses);
    check_value("log pulses, other address", 0, log_pulses);
    end_test();

    start_test("jtag_bypass");
    reset_with_straps(1'b1, 1'b0);
    // TMS low pulls the shared csb pin low
    csb_tms = 1'b0;
    prev = 1'b0;
    for (int i = 0; i < 12; i++) begin
      b = lfsr_bit();
      jtag_bit(b, tdo);
      check_value("tdo", {31'd0, prev}, {31'd0, tdo});
      prev = b;
    end
    jtag_bit(1'b1, tdo);
    check_value("tdo", {31'd0, prev}, {31'd0, tdo});
    check_value("tdo before trst", 1, {31'd0, miso_tdo});
    trst_n = 1'b0;
    wait_clks(4);
    trst_n = 1'b1;
    wait_clks(4);
    check_value("tdo after trst", 0, {31'd0, miso_tdo});
    end_test();

    $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, err_cnt, DUT.u_chk.fail_cnt);
    if (err_cnt == 0 && DUT.u_chk.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+source
source/dbg_boot_pkg.sv
source/ram_bus_if.sv
source/dps_pad_mux.sv
source/spi_boot_loader.sv
source/ram_main.sv
source/sw_status_snoop.sv
source/dbg_boot_top.sv
bench/dbg_boot_chk.sv
bench/tb_dbg_boot.sv

// File: Bender.yml
package:
  name: dbg_boot

export_include_dirs:
  - source

sources:
  - files:
      - source/dbg_boot_pkg.sv
      - source/ram_bus_if.sv
      - source/dps_pad_mux.sv
      - source/spi_boot_loader.sv
      - source/ram_main.sv
      - source/sw_status_snoop.sv
      - source/dbg_boot_top.sv
  - target: test
    files:
      - bench/dbg_boot_chk.sv
      - bench/tb_dbg_boot.sv
